// File: sim.f
source/ahb_sub_pkg.sv
source/ahb_addr_phase.sv
source/ahb_sub_mem.sv
source/ahb_resp_fsm.sv
source/ahb_mem_sub.sv
test/ahb_mem_sub_chk.sv
test/tb_ahb_mem_sub.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the AHB memory subordinate testbench with Verilator

set -u
cd "$(dirname "$0")"

LOG=sim.log
MDIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sim.f --top-module tb_ahb_mem_sub --Mdir "$MDIR"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$MDIR/Vtb_ahb_mem_sub" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation finished cleanly"
exit 0

// File: test/tb_ahb_mem_sub.sv
/*
 * Testbench for the AHB memory subordinate.
 * Drives pipelined transfers on the falling edge, predicts every
 * data phase with a reference model and compares the responses.
 */

`timescale 1ns/1ps

module tb_ahb_mem_sub;

  import ahb_sub_pkg::*;

  localparam int          MEM_DEPTH  = 16;
  localparam int          WAIT_LIMIT = 20;   // Cycles per wait loop
  localparam logic [31:0] SEED       = 32'h3bbba567;

  typedef logic [DATA_WIDTH-1:0] model_t [MEM_DEPTH];

  typedef struct packed {
    logic                  err;
    logic                  write;
    logic [DATA_WIDTH-1:0] rdata;
  } exp_t;

  logic                  HCLK;
  logic                  HRESETn;
  logic                  hsel;
  logic                  hwrite;
  logic                  hready;
  logic                  hready_out;
  logic [ADDR_WIDTH-1:0] haddr;
  htrans_e               htrans;
  hsize_e                hsize;
  logic [DATA_WIDTH-1:0] hwdata;
  logic [DATA_WIDTH-1:0] hrdata;
  hresp_e                hresp;

  model_t                model;
  exp_t                  dp_q[$];   // Accepted transfers awaiting their data phase
  logic [DATA_WIDTH-1:0] pend_wdata;
  logic [31:0]           lcg_state;

  assign hready = hready_out; // Single subordinate on the bus

  ahb_mem_sub #(.MEM_DEPTH(MEM_DEPTH)) i_ahb_mem_sub (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hsize      (hsize),
    .hwdata     (hwdata),
    .hready     (hready),
    .hrdata     (hrdata),
    .hresp      (hresp),
    .hready_out (hready_out)
  );

  bind ahb_mem_sub ahb_mem_sub_chk i_chk (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .hready_out (hready_out),
    .hresp      (hresp)
  );

  initial begin
    HCLK = 1'b0;
    forever #20 HCLK = ~HCLK;
  end

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
    $display("test failed");
    $fatal(1, "stopped on timeout");
  endtask

  // Expected response and read word of one active transfer with the model updated on a good write
  function automatic exp_t ref_xfer(inout model_t mdl, input logic [ADDR_WIDTH-1:0] addr,
                                    input hsize_e size, input logic wr,
                                    input logic [DATA_WIDTH-1:0] wdata);
    exp_t e;
    int   nbytes;
    int   first;
    int   idx;
    e.err   = 1'b0;
    e.write = wr;
    e.rdata = '0;
    first   = int'(addr[1:0]);
    nbytes  = 1 << int'(size);
    idx     = int'(addr[5:2]);
    if (size > WORD) begin
      e.err = 1'b1;
    end else if ((first % nbytes) != 0) begin
      e.err = 1'b1;
    end else if (addr[ADDR_WIDTH-1:2] >= 30'(MEM_DEPTH)) begin
      e.err = 1'b1;
    end
    if (!e.err && wr) begin
      for (int b = first; b < first + nbytes; b++) begin
        mdl[idx][8*b +: 8] = wdata[8*b +: 8];
      end
    end else if (!e.err) begin
      e.rdata = mdl[idx];
    end
    return e;
  endfunction

  // One address phase from one falling edge to the next
  task automatic issue(input logic sel, input htrans_e trans, input logic wr, input hsize_e size,
                       input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] wdata);
    int   waited;
    exp_t e;
    waited = 0;
    hsel   <= sel;
    htrans <= trans;
    hwrite <= wr;
    hsize  <= size;
    haddr  <= addr;
    hwdata <= pend_wdata; // Previous beat's data phase
    while (hready_out !== 1'b1) begin
      @(negedge HCLK);
      waited++;
      if (waited > WAIT_LIMIT) timeout_fail("hready_out to accept an address phase");
    end
    @(posedge HCLK);
    if (sel && (trans == NONSEQ || trans == SEQ)) begin
      e = ref_xfer(model, addr, size, wr, wdata);
      dp_q.push_back(e);
    end
    pend_wdata = wdata;
    @(negedge HCLK);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    issue(1'b0, IDLE, 1'b0, BYTE, '0, '0);
    while (dp_q.size() != 0) begin
      @(posedge HCLK);
      waited++;
      if (waited > WAIT_LIMIT) timeout_fail("the last data phases to complete");
    end
  endtask

  // --------------------
  // Comparison
  // --------------------
  initial begin : compare_proc
    exp_t e;
    logic in_second;
    in_second = 1'b0;
    forever begin
      @(negedge HCLK);
      if (HRESETn && dp_q.size() == 0) begin
        check_val("hready_out", 32'(hready_out), 32'd1); // Idle data phase
        check_val("hresp", 32'(hresp), 32'(OKAY));
      end else if (HRESETn) begin
        e = dp_q[0];
        if (e.err && !in_second) begin
          check_val("hready_out", 32'(hready_out), 32'd0);
          check_val("hresp", 32'(hresp), 32'(ERROR));
          in_second = 1'b1;
        end else begin
          check_val("hready_out", 32'(hready_out), 32'd1);
          check_val("hresp", 32'(hresp), e.err ? 32'(ERROR) : 32'(OKAY));
          if (!e.err && !e.write) check_val("hrdata", hrdata, e.rdata);
          in_second = 1'b0;
          void'(dp_q.pop_front());
        end
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin : main_proc
    logic [31:0] r;
    HRESETn    = 1'b0;
    hsel       = 1'b0;
    hwrite     = 1'b0;
    haddr      = '0;
    htrans     = IDLE;
    hsize      = BYTE;
    hwdata     = '0;
    pend_wdata = '0;
    lcg_state  = SEED;
    for (int i = 0; i < MEM_DEPTH; i++) model[i] = '0;
    repeat (8) @(negedge HCLK);
    HRESETn <= 1'b1;
    @(negedge HCLK);
    check_val("hready_out", 32'(hready_out), 32'd1);
    check_val("hresp", 32'(hresp), 32'(OKAY));

    // Reset contents read back as zero
    for (int i = 0; i < MEM_DEPTH; i++) issue(1'b1, NONSEQ, 1'b0, WORD, 32'(i * 4), '0);
    // Full word pass and back-to-back reads
    for (int i = 0; i < MEM_DEPTH; i++) begin
      issue(1'b1, i == 0 ? NONSEQ : SEQ, 1'b1, WORD, 32'(i * 4), lcg_next());
    end
    for (int i = 0; i < MEM_DEPTH; i++) begin
      issue(1'b1, i == 0 ? NONSEQ : SEQ, 1'b0, WORD, 32'(i * 4), '0);
    end

    // Lane merging with junk in the unused lanes
    issue(1'b1, NONSEQ, 1'b1, BYTE, 32'h20, 32'hEEEEEEA1);
    issue(1'b1, NONSEQ, 1'b1, BYTE, 32'h21, 32'hEEEEB2EE);
    issue(1'b1, NONSEQ, 1'b1, HALF, 32'h22, 32'hC3D4EEEE);
    issue(1'b1, NONSEQ, 1'b1, HALF, 32'h24, 32'hEEEE5566);
    issue(1'b1, NONSEQ, 1'b1, BYTE, 32'h27, 32'h77EEEEEE);
    issue(1'b1, NONSEQ, 1'b0, WORD, 32'h20, '0);
    issue(1'b1, NONSEQ, 1'b0, WORD, 32'h24, '0);

    // Faults that must not touch memory
    issue(1'b1, NONSEQ, 1'b1, WORD, 32'h40, 32'hDEADBEEF);
    issue(1'b1, NONSEQ, 1'b1, HALF, 32'h09, 32'h12345678);
    issue(1'b1, NONSEQ, 1'b1, WORD, 32'h0A, 32'h9ABCDEF0);
    issue(1'b1, NONSEQ, 1'b1, WORD2, 32'h0C, 32'h0BADF00D);
    issue(1'b1, NONSEQ, 1'b0, WORD, 32'h7C, '0);
    issue(1'b1, NONSEQ, 1'b0, WORD, 32'h00, '0);
    issue(1'b1, NONSEQ, 1'b0, WORD, 32'h08, '0);
    issue(1'b1, NONSEQ, 1'b0, WORD, 32'h0C, '0);

    for (int n = 0; n < 200; n++) begin
      r = lcg_next();
      issue(r[31:30] != 2'b00, htrans_e'(r[29:28]), r[27], hsize_e'({1'b0, r[26:25]}),
            {25'd0, r[24:18]}, lcg_next());
    end
    for (int i = 0; i < MEM_DEPTH; i++) issue(1'b1, NONSEQ, 1'b0, WORD, 32'(i * 4), '0);
    drain();

    $display("test passed");
    $finish;
  end

endmodule

// File: test/ahb_mem_sub_chk.sv
/*
 * AHB response protocol checker.
 * Bound into the memory subordinate; watches the two-cycle
 * ERROR response and the ready level after reset.
 */

`timescale 1ns/1ps

module ahb_mem_sub_chk (
  input logic                HCLK,
  input logic                HRESETn,
  input logic                hready_out,
  input ahb_sub_pkg::hresp_e hresp
);

  import ahb_sub_pkg::*;

  // --------------------
  // ERROR response
  // --------------------
  // Cycle one of an error leads straight into cycle two
  err_two_cycle: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (!hready_out && hresp == ERROR) |=> (hready_out && hresp == ERROR)
  ) else $error("ERROR cycle one was not followed by ERROR with hready_out high");

  no_okay_wait: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (hresp == OKAY) |-> hready_out   // Zero wait states on OKAY
  ) else $error("hready_out low while hresp is OKAY");

  // --------------------
  // Reset exit
  // --------------------
  ready_after_reset: assert property (
    @(posedge HCLK) $rose(HRESETn) |-> hready_out
  ) else $error("hready_out low in the first cycle after reset");

endmodule

// File: source/ahb_mem_sub.sv
/*
 * Zero-wait-state AHB memory subordinate.
 * Address-phase front end feeding the memory array and the
 * response sequencer side by side.
 */

`timescale 1ns/1ps

module ahb_mem_sub #(
  parameter int MEM_DEPTH = 16
) (
  input  logic                               HCLK,
  input  logic                               HRESETn,
  input  logic                               hsel,
  input  logic [ahb_sub_pkg::ADDR_WIDTH-1:0] haddr,
  input  ahb_sub_pkg::htrans_e               htrans,
  input  logic                               hwrite,
  input  ahb_sub_pkg::hsize_e                hsize,
  input  logic [ahb_sub_pkg::DATA_WIDTH-1:0] hwdata,
  input  logic                               hready,
  output logic [ahb_sub_pkg::DATA_WIDTH-1:0] hrdata,
  output ahb_sub_pkg::hresp_e                hresp,
  output logic                               hready_out
);

  import ahb_sub_pkg::*;

  xfer_t dp_xfer; // Transfer now in its data phase

  ahb_addr_phase #(.MEM_DEPTH(MEM_DEPTH)) i_addr_phase (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .hsel    (hsel),
    .hwrite  (hwrite),
    .haddr   (haddr),
    .htrans  (htrans),
    .hsize   (hsize),
    .hready  (hready),
    .dp_xfer (dp_xfer)
  );

  ahb_sub_mem #(.MEM_DEPTH(MEM_DEPTH)) i_mem (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .hready  (hready),
    .dp_xfer (dp_xfer),
    .hwdata  (hwdata),
    .rdata   (hrdata)
  );

  ahb_resp_fsm i_resp (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .hready     (hready),
    .dp_xfer    (dp_xfer),
    .hready_out (hready_out),
    .hresp      (hresp)
  );

endmodule

// File: source/ahb_resp_fsm.sv
/*
 * AHB response sequencer.
 * Drives hready_out and hresp for the data phase, stretching an
 * error transfer into the two-cycle ERROR response.
 */

`timescale 1ns/1ps

module ahb_resp_fsm (
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  logic                 hready,
  input  ahb_sub_pkg::xfer_t   dp_xfer,
  output logic                 hready_out,
  output ahb_sub_pkg::hresp_e  hresp
);

  import ahb_sub_pkg::*;

  logic err_now;    // Valid transfer with a fault in its data phase
  logic err_second; // Second cycle of the error response
  logic err_first;

  assign err_now   = dp_xfer.valid && dp_xfer.err;
  assign err_first = err_now && !err_second;

  // --------------------
  // State
  // --------------------
  // Set as cycle one ends with the bus held low and cleared one edge later
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      err_second <= 1'b0;
    end else begin
      err_second <= err_first && !hready;
    end
  end

  // --------------------
  // Outputs
  // --------------------
  always_comb begin
    hready_out = 1'b1;
    hresp      = OKAY;
    if (err_now) begin
      hresp      = ERROR;
      hready_out = !err_first; // Wait state in cycle one only
    end
  end

endmodule

// File: source/ahb_sub_mem.sv
/*
 * AHB subordinate memory array.
 * Word-organised storage written through byte lanes at the end
 * of the data phase, with combinational read of the full word.
 */

`timescale 1ns/1ps

module ahb_sub_mem #(
  parameter int MEM_DEPTH = 16
) (
  input  logic                               HCLK,
  input  logic                               HRESETn,
  input  logic                               hready,
  input  ahb_sub_pkg::xfer_t                 dp_xfer,
  input  logic [ahb_sub_pkg::DATA_WIDTH-1:0] hwdata,
  output logic [ahb_sub_pkg::DATA_WIDTH-1:0] rdata
);

  import ahb_sub_pkg::*;

  localparam int IDX_W = $clog2(MEM_DEPTH);

  logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];
  logic [IDX_W-1:0]      word_idx;
  logic [STRB_WIDTH-1:0] lane_en;
  logic                  wr_en;

  assign word_idx = dp_xfer.addr[IDX_W+1:2];

  // --------------------
  // Byte-lane enables
  // --------------------
  always_comb begin
    case (dp_xfer.size)
      BYTE:    lane_en = STRB_WIDTH'(1) << dp_xfer.addr[1:0];
      HALF:    lane_en = STRB_WIDTH'(3) << {dp_xfer.addr[1], 1'b0};
      WORD:    lane_en = '1;
      default: lane_en = '0;
    endcase
  end

  // Only a clean write whose data phase completes this edge
  assign wr_en = hready && dp_xfer.valid && dp_xfer.write && !dp_xfer.err;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      for (int i = 0; i < MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (lane_en[b]) begin
          mem[word_idx][8*b +: 8] <= hwdata[8*b +: 8];
        end
      end
    end
  end

  // Whole word with lanes already in address position
  assign rdata = mem[word_idx];

endmodule

// File: source/ahb_addr_phase.sv
/*
 * AHB address-phase front end.
 * Samples the address phase on an accepting edge, checks size,
 * alignment and range, and holds the result as the transfer
 * in its data phase.
 */

`timescale 1ns/1ps

module ahb_addr_phase #(
  parameter int MEM_DEPTH = 16
) (
  input  logic                               HCLK,
  input  logic                               HRESETn,
  input  logic                               hsel,
  input  logic                               hwrite,
  input  logic [ahb_sub_pkg::ADDR_WIDTH-1:0] haddr,
  input  ahb_sub_pkg::htrans_e               htrans,
  input  ahb_sub_pkg::hsize_e                hsize,
  input  logic                               hready,
  output ahb_sub_pkg::xfer_t                 dp_xfer
);

  import ahb_sub_pkg::*;

  // Number of words as a word-index value
  localparam logic [ADDR_WIDTH-3:0] DEPTH_IDX = (ADDR_WIDTH-2)'(MEM_DEPTH);

  logic  active;
  logic  size_bad;
  logic  misaligned;
  logic  out_of_range;
  xfer_t next_xfer;

  // --------------------
  // Address checks
  // --------------------
  assign active       = hsel && (htrans == NONSEQ || htrans == SEQ);
  assign size_bad     = hsize > WORD;
  assign out_of_range = haddr[ADDR_WIDTH-1:2] >= DEPTH_IDX;

  always_comb begin
    case (hsize)
      HALF:    misaligned = haddr[0];
      WORD:    misaligned = |haddr[1:0];
      default: misaligned = 1'b0; // Bytes always aligned
    endcase
  end

  always_comb begin
    next_xfer.valid = active;
    next_xfer.write = hwrite;
    next_xfer.err   = active && (size_bad || misaligned || out_of_range);
    next_xfer.size  = hsize;
    next_xfer.addr  = haddr;
  end

  // --------------------
  // Data-phase register
  // --------------------
  // Holds while a wait state stretches the current data phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dp_xfer <= '0;
    end else if (hready) begin
      dp_xfer <= next_xfer;
    end
  end

endmodule

// File: source/ahb_sub_pkg.sv
/*
 * AHB memory subordinate package.
 * Bus widths, transfer type, size and response encodings,
 * and the captured transfer carried from the address phase
 * into the data phase.
 */

package ahb_sub_pkg;

  // --------------------
  // Bus widths
  // --------------------
  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8; // Byte lanes

  // --------------------
  // Encodings
  // --------------------
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Sizes above WORD are illegal on this 32-bit bus
  typedef enum logic [2:0] {
    BYTE   = 3'b000,
    HALF   = 3'b001,
    WORD   = 3'b010,
    WORD2  = 3'b011,
    WORD4  = 3'b100,
    WORD8  = 3'b101,
    WORD16 = 3'b110,
    WORD32 = 3'b111
  } hsize_e;

  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  // --------------------
  // Data-phase transfer
  // --------------------
  typedef struct packed {
    logic                  valid; // NONSEQ or SEQ while selected
    logic                  write;
    logic                  err;   // Size, alignment or range fault
    hsize_e                size;
    logic [ADDR_WIDTH-1:0] addr;
  } xfer_t;

endpackage
